/* bench/cache_checker.sv */
// shadow starts as the memory fill pattern; assumes one processor request at a time
`timescale 1ns/1ns
`include "dm_cache_cfg.svh"

module cache_checker (
	input  logic                       clk,
	input  logic                       proc_reset,
	input  logic                       proc_read,
	input  logic                       proc_write,
	input  cache_geom_pkg::word_addr_t proc_addr,
	input  cache_geom_pkg::word_t      proc_wdata,
	input  cache_geom_pkg::word_t      proc_rdata,
	input  logic                       proc_stall,
	input  logic                       mem_read,
	input  logic                       mem_write,
	input  cache_geom_pkg::line_addr_t mem_addr,
	input  cache_geom_pkg::line_t      mem_wdata,
	input  logic                       mem_ready,
	// row in flight
	input  logic [8*12-1:0]            row_name,
	input  logic                       exp_fill,
	input  logic                       exp_evict,
	input  cache_geom_pkg::line_addr_t exp_victim,
	output int                         tests_run,
	output int                         tests_failed
);

	localparam int WORDS = 1 << `CACHE_OFFSET_W;

	cache_geom_pkg::word_t shadow [cache_geom_pkg::word_addr_t];
	cache_geom_pkg::word_t exp_w;
	cache_geom_pkg::word_t act_w;
	int   run_count  = 0;
	int   fail_count = 0;
	int   fills      = 0;  // refills seen in this row
	int   evicts     = 0;
	logic row_bad    = 1'b0;
	logic reset_bad  = 1'b0;
	logic reset_d    = 1'b0;

	assign tests_run    = run_count;
	assign tests_failed = fail_count;

	function automatic cache_geom_pkg::word_t expected_word(input cache_geom_pkg::word_addr_t a);
		if (shadow.exists(a))
			return shadow[a];
		return cache_geom_pkg::word_t'(a) ^ 32'hA5A5_0000;  // never written
	endfunction

	always @(posedge clk) begin
		// ------------------------------------------------------------
		// reset and the idle cycle after it
		if (proc_reset || reset_d) begin
			if (!proc_stall || mem_read || mem_write)
				reset_bad = 1'b1;
		end
		if (!proc_reset && reset_d) begin
			run_count++;
			if (reset_bad) begin
				fail_count++;
				$display("reset: stall low or a memory request during reset or the idle cycle");
			end else begin
				$display("PASS reset");
			end
		end
		reset_d = proc_reset;

		if (!proc_reset) begin
			if (mem_write && mem_ready) begin
				evicts++;
				if (fills != 0) begin
					row_bad = 1'b1;
					$display("%0s: write-back came after the refill", row_name);
				end
				if (mem_addr !== exp_victim) begin
					row_bad = 1'b1;
					$display("FAIL %0s victim address expected %h actual %h",
						row_name, exp_victim, mem_addr);
				end
				for (int w = 0; w < WORDS; w++) begin
					exp_w = expected_word({mem_addr, cache_geom_pkg::offset_t'(w)});
					act_w = mem_wdata[w*`CACHE_WORD_W +: `CACHE_WORD_W];
					if (act_w !== exp_w) begin
						row_bad = 1'b1;
						$display("FAIL %0s victim word %0d expected %h actual %h",
							row_name, w, exp_w, act_w);
					end
				end
			end
			if (mem_read && mem_ready)
				fills++;

			// access completes in the cycle stall is low
			if ((proc_read || proc_write) && !proc_stall) begin
				if (proc_read) begin
					exp_w = expected_word(proc_addr);
					if (proc_rdata !== exp_w) begin
						row_bad = 1'b1;
						$display("FAIL %0s read data expected %h actual %h",
							row_name, exp_w, proc_rdata);
					end
				end else begin
					shadow[proc_addr] = proc_wdata;
				end
				if (fills != int'(exp_fill)) begin
					row_bad = 1'b1;
					$display("FAIL %0s refills expected %0d actual %0d", row_name, exp_fill, fills);
				end
				if (evicts != int'(exp_evict)) begin
					row_bad = 1'b1;
					$display("FAIL %0s write-backs expected %0d actual %0d",
						row_name, exp_evict, evicts);
				end
				run_count++;
				if (row_bad)
					fail_count++;
				else
					$display("PASS %0s", row_name);
				fills   = 0;
				evicts  = 0;
				row_bad = 1'b0;
			end
		end
	end

endmodule

/* bench/dm_cache_properties.sv */
// memory port handshake rules, bound into every dm_cache; reset only checks proc_stall
`timescale 1ns/1ns

module dm_cache_properties (
	input logic                       clk,
	input logic                       proc_reset,
	input logic                       proc_stall,
	input logic                       mem_read,
	input logic                       mem_write,
	input logic                       mem_ready,
	input cache_geom_pkg::line_addr_t mem_addr,
	input cache_geom_pkg::line_t      mem_wdata
);

	// one memory request at a time
	one_request: assert property (@(posedge clk) disable iff (proc_reset)
		!(mem_read && mem_write))
		else $error("mem_read and mem_write are high together");

	// ------------------------------------------------------------
	// requests held until mem_ready
	read_held: assert property (@(posedge clk) disable iff (proc_reset)
		(mem_read && !mem_ready) |=> (mem_read && $stable(mem_addr)))
		else $error("mem_read or its address changed before mem_ready");

	write_held: assert property (@(posedge clk) disable iff (proc_reset)
		(mem_write && !mem_ready) |=> (mem_write && $stable(mem_addr) && $stable(mem_wdata)))
		else $error("mem_write, its address or its line changed before mem_ready");

	// request drops right after acceptance
	read_drops: assert property (@(posedge clk) disable iff (proc_reset)
		(mem_read && mem_ready) |=> !mem_read)
		else $error("mem_read still high the cycle after mem_ready");

	write_drops: assert property (@(posedge clk) disable iff (proc_reset)
		(mem_write && mem_ready) |=> !mem_write)
		else $error("mem_write still high the cycle after mem_ready");

	stall_in_reset: assert property (@(posedge clk) proc_reset |-> proc_stall)
		else $error("proc_stall low during reset");

endmodule

bind dm_cache dm_cache_properties props0 (
	.clk        (clk),
	.proc_reset (proc_reset),
	.proc_stall (proc_stall),
	.mem_read   (mem_read),
	.mem_write  (mem_write),
	.mem_ready  (mem_ready),
	.mem_addr   (mem_addr),
	.mem_wdata  (mem_wdata)
);

/* bench/tb_dm_cache.sv */
// fixed row table then 60 random rows; memory answers every request after MEM_LATENCY cycles
`timescale 1ns/1ns
`include "dm_cache_cfg.svh"

module tb_dm_cache;

	localparam int MEM_LATENCY    = 3;
	localparam int DIRECTED_ROWS  = 10;
	localparam int RANDOM_ROWS    = 60;
	localparam int NUM_ROWS       = DIRECTED_ROWS + RANDOM_ROWS;
	localparam int TIMEOUT_CYCLES = 16 + NUM_ROWS * (2 * MEM_LATENCY + 6);
	localparam int WORDS          = 1 << `CACHE_OFFSET_W;
	localparam int LINES          = 1 << `CACHE_INDEX_W;

	typedef struct packed {
		logic [8*12-1:0]            name;
		logic                       wr;
		cache_geom_pkg::word_addr_t addr;
		cache_geom_pkg::word_t      wdata;
		logic                       fill;    // expected refill
		logic                       evict;   // expected write-back
		cache_geom_pkg::line_addr_t victim;
	} row_t;

	logic                       clk        = 1'b0;
	logic                       proc_reset = 1'b1;
	logic                       proc_read  = 1'b0;
	logic                       proc_write = 1'b0;
	cache_geom_pkg::word_addr_t proc_addr  = '0;
	cache_geom_pkg::word_t      proc_wdata = '0;
	cache_geom_pkg::word_t      proc_rdata;
	logic                       proc_stall;
	logic                       mem_read;
	logic                       mem_write;
	cache_geom_pkg::line_addr_t mem_addr;
	cache_geom_pkg::line_t      mem_wdata;
	cache_geom_pkg::line_t      mem_rdata  = '0;
	logic                       mem_ready  = 1'b0;

	logic [8*12-1:0]            row_name   = '0;
	logic                       exp_fill   = 1'b0;
	logic                       exp_evict  = 1'b0;
	cache_geom_pkg::line_addr_t exp_victim = '0;
	int                         tests_run;
	int                         tests_failed;

	row_t                       rows [$];
	cache_geom_pkg::line_t      mem_lines [cache_geom_pkg::line_addr_t];
	int                         wait_count  = 0;
	int                         cycle_count = 0;
	logic [31:0]                rng = 32'd83;
	cache_geom_pkg::tag_t       tags [4] = '{25'h0ABCDE, 25'h1F0001, 25'h0000013, 25'h155555};

	// resident line per index, predicts traffic for the random rows
	logic                       model_valid [LINES];
	logic                       model_dirty [LINES];
	cache_geom_pkg::line_addr_t model_line [LINES];

	initial begin
		forever #20 clk = ~clk;
	end

	dm_cache dut0 (
		.clk(clk), .proc_reset(proc_reset),
		.proc_read(proc_read), .proc_write(proc_write),
		.proc_addr(proc_addr), .proc_wdata(proc_wdata),
		.proc_rdata(proc_rdata), .proc_stall(proc_stall),
		.mem_read(mem_read), .mem_write(mem_write),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata), .mem_ready(mem_ready)
	);

	cache_checker chk0 (
		.clk(clk), .proc_reset(proc_reset),
		.proc_read(proc_read), .proc_write(proc_write),
		.proc_addr(proc_addr), .proc_wdata(proc_wdata),
		.proc_rdata(proc_rdata), .proc_stall(proc_stall),
		.mem_read(mem_read), .mem_write(mem_write),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_ready(mem_ready),
		.row_name(row_name), .exp_fill(exp_fill), .exp_evict(exp_evict),
		.exp_victim(exp_victim), .tests_run(tests_run), .tests_failed(tests_failed)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		return s;
	endfunction

	function automatic cache_geom_pkg::line_t fill_line(input cache_geom_pkg::line_addr_t la);
		cache_geom_pkg::line_t l;
		for (int w = 0; w < WORDS; w++)
			l[w*`CACHE_WORD_W +: `CACHE_WORD_W] =
				cache_geom_pkg::word_t'({la, cache_geom_pkg::offset_t'(w)}) ^ 32'hA5A5_0000;
		return l;
	endfunction

	function automatic cache_geom_pkg::word_addr_t addr_of(input cache_geom_pkg::tag_t t,
			input cache_geom_pkg::index_t i, input cache_geom_pkg::offset_t o);
		return {t, i, o};
	endfunction

	task automatic add_row(input logic [8*12-1:0] name, input logic wr,
			input cache_geom_pkg::word_addr_t addr, input cache_geom_pkg::word_t wdata,
			input logic fill, input logic evict, input cache_geom_pkg::line_addr_t victim);
		cache_geom_pkg::index_t     idx;
		cache_geom_pkg::line_addr_t la;
		idx = addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
		la  = addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W];
		rows.push_back('{name, wr, addr, wdata, fill, evict, victim});
		if (!model_valid[idx] || model_line[idx] != la)
			model_dirty[idx] = 1'b0;  // refilled clean
		model_valid[idx] = 1'b1;
		model_line[idx]  = la;
		model_dirty[idx] = model_dirty[idx] | wr;
	endtask

	task automatic add_random_row(input int n);
		cache_geom_pkg::word_addr_t addr;
		cache_geom_pkg::index_t     idx;
		logic                       miss;
		logic [31:0]                pick;
		rng  = xorshift32(rng);
		pick = rng;
		rng  = xorshift32(rng);
		addr = addr_of(tags[pick[1:0]], pick[4:2], pick[6:5]);
		idx  = pick[4:2];
		miss = !model_valid[idx] || model_line[idx] != addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W];
		add_row({"rand_", 8'd48 + 8'(n / 10), 8'd48 + 8'(n % 10)}, pick[7], addr, rng,
			miss, miss && model_valid[idx] && model_dirty[idx], model_line[idx]);
	endtask

	// ------------------------------------------------------------
	// memory model, one answer per request
	always @(negedge clk) begin
		if (proc_reset || mem_ready) begin
			mem_ready  = 1'b0;
			wait_count = 0;
		end else if (mem_read || mem_write) begin
			wait_count++;
			if (wait_count >= MEM_LATENCY) begin
				if (mem_write)
					mem_lines[mem_addr] = mem_wdata;
				else
					mem_rdata = mem_lines.exists(mem_addr) ? mem_lines[mem_addr]
					                                       : fill_line(mem_addr);
				mem_ready = 1'b1;
			end
		end
	end

	initial begin
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: stimulus did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("test failed");
		$finish;
	end

	// ------------------------------------------------------------
	// stimulus
	initial begin
		for (int i = 0; i < LINES; i++) begin
			model_valid[i] = 1'b0;
			model_dirty[i] = 1'b0;
			model_line[i]  = '0;
		end
		add_row("rd_miss", 1'b0, addr_of(tags[0], 3'd2, 2'd1), '0, 1'b1, 1'b0, '0);
		add_row("rd_hit_w0", 1'b0, addr_of(tags[0], 3'd2, 2'd0), '0, 1'b0, 1'b0, '0);
		add_row("rd_hit_w1", 1'b0, addr_of(tags[0], 3'd2, 2'd1), '0, 1'b0, 1'b0, '0);
		add_row("rd_hit_w2", 1'b0, addr_of(tags[0], 3'd2, 2'd2), '0, 1'b0, 1'b0, '0);
		add_row("rd_hit_w3", 1'b0, addr_of(tags[0], 3'd2, 2'd3), '0, 1'b0, 1'b0, '0);
		add_row("wr_hit", 1'b1, addr_of(tags[0], 3'd2, 2'd2), 32'hDEAD_BEEF, 1'b0, 1'b0, '0);
		add_row("rd_after_wr", 1'b0, addr_of(tags[0], 3'd2, 2'd2), '0, 1'b0, 1'b0, '0);
		add_row("dirty_evict", 1'b0, addr_of(tags[1], 3'd2, 2'd0), '0, 1'b1, 1'b1,
			{tags[0], 3'd2});
		add_row("clean_evict", 1'b0, addr_of(tags[0], 3'd2, 2'd2), '0, 1'b1, 1'b0, '0);
		add_row("wr_miss", 1'b1, addr_of(tags[2], 3'd5, 2'd3), 32'h0123_4567, 1'b1, 1'b0, '0);
		for (int n = 0; n < RANDOM_ROWS; n++)
			add_random_row(n);

		repeat (16) @(negedge clk);
		proc_reset = 1'b0;
		@(negedge clk);  // idle cycle with no request, stall must stay high on its own
		foreach (rows[i]) begin
			proc_read  = !rows[i].wr;
			proc_write = rows[i].wr;
			proc_addr  = rows[i].addr;
			proc_wdata = rows[i].wdata;
			row_name   = rows[i].name;
			exp_fill   = rows[i].fill;
			exp_evict  = rows[i].evict;
			exp_victim = rows[i].victim;
			do @(posedge clk); while (proc_stall);
			@(negedge clk);
		end
		proc_read  = 1'b0;
		proc_write = 1'b0;
		repeat (2) @(negedge clk);

		$display("%0d tests run, %0d passed, %0d failed", tests_run,
			tests_run - tests_failed, tests_failed);
		if (tests_failed == 0 && tests_run == NUM_ROWS + 1) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

/* dm_cache.f */
+incdir+logic
logic/cache_geom_pkg.sv
logic/cache_ctrl_pkg.sv
logic/line_store_if.sv
logic/line_array.sv
logic/cache_controller.sv
logic/dm_cache.sv
bench/dm_cache_properties.sv
bench/cache_checker.sv
bench/tb_dm_cache.sv

/* logic/cache_controller.sv */
// one processor request at a time; requester holds read/write, address and data while stalled
`timescale 1ns/1ns
`include "dm_cache_cfg.svh"

module cache_controller (
	input  logic                       clk,
	input  logic                       proc_reset,
	// processor side
	input  logic                       proc_read,
	input  logic                       proc_write,
	input  cache_geom_pkg::word_addr_t proc_addr,
	input  cache_geom_pkg::word_t      proc_wdata,
	output cache_geom_pkg::word_t      proc_rdata,
	output logic                       proc_stall,
	// memory side
	output logic                       mem_read,
	output logic                       mem_write,
	output cache_geom_pkg::line_addr_t mem_addr,
	output cache_geom_pkg::line_t      mem_wdata,
	input  cache_geom_pkg::line_t      mem_rdata,
	input  logic                       mem_ready,
	// storage
	line_store_if.ctrl                 store
);

	cache_ctrl_pkg::cache_state_t state, state_nxt;
	logic                         finish, finish_nxt;

	cache_geom_pkg::tag_t         req_tag;
	cache_geom_pkg::index_t       req_index;
	cache_geom_pkg::offset_t      req_offset;
	cache_geom_pkg::tag_entry_t   entry;
	cache_geom_pkg::tag_entry_t   meta_next;
	cache_geom_pkg::line_t        merged_line;
	cache_geom_pkg::line_t        line_next;
	logic                         req;
	logic                         hit;
	logic                         accept;
	logic                         meta_we;
	logic                         line_we;

	// ------------------------------------------------------------
	// address split and hit
	assign req_tag    = proc_addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
	assign req_index  = proc_addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
	assign req_offset = proc_addr[`CACHE_OFFSET_W-1:0];

	assign store.index = req_index;
	assign entry       = store.meta_rdata;

	assign req    = proc_read | proc_write;
	assign hit    = entry.valid && (entry.tag == req_tag);
	assign accept = mem_ready & ~finish;  // one acceptance per request

	// ------------------------------------------------------------
	// word select and merge
	assign proc_rdata = store.line_rdata[req_offset*`CACHE_WORD_W +: `CACHE_WORD_W];

	always_comb begin
		merged_line = store.line_rdata;
		merged_line[req_offset*`CACHE_WORD_W +: `CACHE_WORD_W] = proc_wdata;
	end

	// victim address only while writing back, else the request's line
	assign mem_addr  = (state == cache_ctrl_pkg::WRITE_BACK) ? {entry.tag, req_index}
	                                                         : {req_tag, req_index};
	assign mem_wdata = store.line_rdata;

	// ------------------------------------------------------------
	// miss FSM
	always_comb begin
		state_nxt  = state;
		finish_nxt = 1'b0;
		proc_stall = 1'b1;
		mem_read   = 1'b0;
		mem_write  = 1'b0;
		meta_we    = 1'b0;
		meta_next  = entry;
		line_we    = 1'b0;
		line_next  = merged_line;

		case (state)
			cache_ctrl_pkg::IDLE: begin
				state_nxt = cache_ctrl_pkg::COMPARE;
			end

			cache_ctrl_pkg::COMPARE: begin
				proc_stall = req & ~hit;
				if (req && hit) begin
					if (proc_write) begin  // write hit stays local
						meta_we         = 1'b1;
						meta_next.dirty = 1'b1;
						line_we         = 1'b1;
					end
				end else if (req) begin
					state_nxt = (entry.valid && entry.dirty) ? cache_ctrl_pkg::WRITE_BACK
					                                         : cache_ctrl_pkg::ALLOCATE;
				end
			end

			cache_ctrl_pkg::WRITE_BACK: begin
				mem_write = ~finish;
				if (accept) begin
					finish_nxt      = 1'b1;
					meta_we         = 1'b1;
					meta_next.dirty = 1'b0;  // memory copy is current now
					state_nxt       = cache_ctrl_pkg::ALLOCATE;
				end
			end

			cache_ctrl_pkg::ALLOCATE: begin
				mem_read = ~finish;  // quiet for a cycle after a write-back
				if (accept) begin
					finish_nxt = 1'b1;
					meta_we    = 1'b1;
					meta_next  = '{valid: 1'b1, dirty: 1'b0, tag: req_tag};
					line_we    = 1'b1;
					line_next  = mem_rdata;
					state_nxt  = cache_ctrl_pkg::COMPARE;  // completes as a hit
				end
			end

			default: begin
				state_nxt = cache_ctrl_pkg::IDLE;
			end
		endcase
	end

	assign store.meta_we    = meta_we;
	assign store.meta_wdata = meta_next;
	assign store.line_we    = line_we;
	assign store.line_wdata = line_next;

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state  <= cache_ctrl_pkg::IDLE;
			finish <= 1'b0;
		end else begin
			state  <= state_nxt;
			finish <= finish_nxt;
		end
	end

endmodule

/* logic/cache_ctrl_pkg.sv */
// controller state encoding; IDLE is zero so an uninitialised register starts idle

package cache_ctrl_pkg;

	// IDLE only lasts the one cycle after reset
	typedef enum logic [1:0] {
		IDLE       = 2'd0,
		COMPARE    = 2'd1,  // tag check, hits served here
		WRITE_BACK = 2'd2,  // dirty victim goes out
		ALLOCATE   = 2'd3   // refill from memory
	} cache_state_t;

endpackage

/* logic/cache_geom_pkg.sv */
// address split and storage entry types; widths come from dm_cache_cfg.svh
`include "dm_cache_cfg.svh"

package cache_geom_pkg;

	// ------------------------------------------------------------
	// processor side
	typedef logic [`CACHE_WORD_W-1:0]   word_t;
	typedef logic [`CACHE_ADDR_W-1:0]   word_addr_t;

	// fields of a word address, msb to lsb: tag, index, offset
	typedef logic [`CACHE_TAG_W-1:0]    tag_t;
	typedef logic [`CACHE_INDEX_W-1:0]  index_t;
	typedef logic [`CACHE_OFFSET_W-1:0] offset_t;

	// ------------------------------------------------------------
	// memory side
	typedef logic [`CACHE_LINE_W-1:0]   line_t;
	// line address is the word address without the offset
	typedef logic [`CACHE_ADDR_W-`CACHE_OFFSET_W-1:0] line_addr_t;

	// one tag store entry, 27 bits
	typedef struct packed {
		logic valid;
		logic dirty;  // line differs from memory
		tag_t tag;
	} tag_entry_t;

endpackage

/* logic/dm_cache.sv */
// direct-mapped write-back cache; proc_stall stays high for the cycle after reset
`timescale 1ns/1ns

module dm_cache (
	input  logic                       clk,
	input  logic                       proc_reset,
	// processor side
	input  logic                       proc_read,
	input  logic                       proc_write,
	input  cache_geom_pkg::word_addr_t proc_addr,
	input  cache_geom_pkg::word_t      proc_wdata,
	output cache_geom_pkg::word_t      proc_rdata,
	output logic                       proc_stall,
	// memory side
	output logic                       mem_read,
	output logic                       mem_write,
	output cache_geom_pkg::line_addr_t mem_addr,
	output cache_geom_pkg::line_t      mem_wdata,
	input  cache_geom_pkg::line_t      mem_rdata,
	input  logic                       mem_ready
);

	line_store_if store_bus ();

	cache_controller u_ctrl (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_read  (proc_read),
		.proc_write (proc_write),
		.proc_addr  (proc_addr),
		.proc_wdata (proc_wdata),
		.proc_rdata (proc_rdata),
		.proc_stall (proc_stall),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready),
		.store      (store_bus.ctrl)
	);

	// ------------------------------------------------------------
	// valid, dirty and tag per line
	line_array #(.entry_t(cache_geom_pkg::tag_entry_t), .depth(1 << $bits(cache_geom_pkg::index_t)))
	tag_store (
		.clk        (clk),
		.proc_reset (proc_reset),
		.index      (store_bus.index),
		.we         (store_bus.meta_we),
		.wdata      (store_bus.meta_wdata),
		.rdata      (store_bus.meta_rdata)
	);

	// line payload, same index as the tags
	line_array #(.entry_t(cache_geom_pkg::line_t), .depth(1 << $bits(cache_geom_pkg::index_t)))
	data_store (
		.clk        (clk),
		.proc_reset (proc_reset),
		.index      (store_bus.index),
		.we         (store_bus.line_we),
		.wdata      (store_bus.line_wdata),
		.rdata      (store_bus.line_rdata)
	);

endmodule

/* logic/dm_cache_cfg.svh */
// cache geometry; tag width is derived, so only change index and offset widths together
`ifndef DM_CACHE_CFG_SVH
`define DM_CACHE_CFG_SVH

// ------------------------------------------------------------
// processor side
`define CACHE_WORD_W   32  // one processor word
`define CACHE_ADDR_W   30  // word address, byte bits already stripped

// ------------------------------------------------------------
// line organisation
`define CACHE_INDEX_W  3   // 8 lines
`define CACHE_OFFSET_W 2   // 4 words per line

`define CACHE_TAG_W    (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_OFFSET_W)
`define CACHE_LINE_W   (`CACHE_WORD_W * (1 << `CACHE_OFFSET_W))

`endif

/* logic/line_array.sv */
// depth must not exceed the range of index_t; reset takes one clock to clear every entry
`timescale 1ns/1ns

module line_array #(
	parameter type entry_t = logic,
	parameter int  depth   = 8
) (
	input  logic                   clk,
	input  logic                   proc_reset,
	input  cache_geom_pkg::index_t index,
	input  logic                   we,
	input  entry_t                 wdata,
	output entry_t                 rdata
);

	entry_t entries [depth];

	// async read, the controller decides hit in the same cycle
	assign rdata = entries[index];

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			for (int i = 0; i < depth; i++) begin
				entries[i] <= '0;  // invalid and clean
			end
		end else if (we) begin
			entries[index] <= wdata;
		end
	end

endmodule

/* logic/line_store_if.sv */
// controller to storage link; reads are combinational at index, writes land on the clock edge
`timescale 1ns/1ns

interface line_store_if;

	cache_geom_pkg::index_t     index;       // shared by both arrays

	// tag store
	logic                       meta_we;
	cache_geom_pkg::tag_entry_t meta_wdata;
	cache_geom_pkg::tag_entry_t meta_rdata;

	// data store
	logic                       line_we;
	cache_geom_pkg::line_t      line_wdata;
	cache_geom_pkg::line_t      line_rdata;

	modport ctrl (
		output index, meta_we, meta_wdata, line_we, line_wdata,
		input  meta_rdata, line_rdata
	);

	modport store (
		input  index, meta_we, meta_wdata, line_we, line_wdata,
		output meta_rdata, line_rdata
	);

endinterface

/* run_sim.sh */
#!/usr/bin/env bash
# builds and runs the dm_cache testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_dm_cache \
	-f dm_cache.f \
	-o sim_dm_cache

./obj_dir/sim_dm_cache 2>&1 | tee sim.log

if grep -q "test failed" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi

echo "simulation clean"
